//--- src.f
hdl/lite_xbar_pkg.sv
hdl/lite_addr_decode.sv
hdl/lite_demux.sv
hdl/lite_mux.sv
hdl/lite_decerr_slv.sv
hdl/lite_xbar.sv
tb/tb_lite_xbar.sv

//--- run.sh
#!/usr/bin/env bash
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --top-module tb_lite_xbar -f src.f \
  && ./obj_dir/Vtb_lite_xbar > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1 || exit 0

//--- tb/tb_lite_xbar.sv
// Random-traffic testbench for the crossbar, with two target memory models and a reference memory
`default_nettype none

module tb_lite_xbar;
  timeunit 1ns;
  timeprecision 100ps;
  import lite_xbar_pkg::*;

  localparam int NumWrites = 100;  // Per initiator
  localparam int NumReads  = 100;
  localparam int MaxCycles = (NumWrites + NumReads) * 40 + 100;

  logic                         clk = 1'b0;
  logic                         rst_n;
  lite_req_t  [NumSlvPorts-1:0] slv_req;
  lite_resp_t [NumSlvPorts-1:0] slv_resp;
  lite_req_t  [NumMstPorts-1:0] mst_req;
  lite_resp_t [NumMstPorts-1:0] mst_resp;
  addr_rule_t [NumRules-1:0]    addr_map;

  logic [15:0] lfsr_q = 16'd53337;
  data_t       tmem    [NumMstPorts][16];  // Target model storage
  data_t       ref_mem [NumMstPorts][16];
  data_t       r_pend  [NumMstPorts][$];   // Read data waiting at each target
  int          b_pend  [NumMstPorts];
  resp_code_t  exp_b   [NumSlvPorts][$];
  r_chan_t     exp_r   [NumSlvPorts][$];
  int          wr_issued [NumSlvPorts];
  int          rd_issued [NumSlvPorts];
  int          open_cnt  [NumSlvPorts];    // Raised requests without a consumed response
  int          mapped_cnt;
  int          tgt_hs_cnt;
  int          rsp_cnt;
  int          err_cnt;
  int          cycle_cnt;

  always #4 clk = ~clk;

  lite_xbar lite_xbar_inst (
    .clk_i      (clk),
    .rst_n_i    (rst_n),
    .slv_req_i  (slv_req),
    .slv_resp_o (slv_resp),
    .mst_req_o  (mst_req),
    .mst_resp_i (mst_resp),
    .addr_map_i (addr_map)
  );

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic data_t merge_strobes(input data_t old_word, input data_t new_word,
                                          input strb_t strb);
    data_t res;
    res = old_word;
    for (int b = 0; b < StrbWidth; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return res;
  endfunction

  // Initiators own alternate words and one region in eight is unmapped
  function automatic addr_t pick_addr(input int i);
    logic [31:0] rnd;
    logic [3:0]  word;
    rnd  = take_bits(15);
    word = {rnd[5:3], i[0]};
    if (rnd[2:0] == 3'd7) begin
      return {1'b1, rnd[14:6], word, 2'b00};
    end
    return {1'b0, rnd[0], 8'h00, word, 2'b00};
  endfunction

  function automatic logic traffic_done();
    logic done;
    done = 1'b1;
    for (int i = 0; i < NumSlvPorts; i++) begin
      if (wr_issued[i] != NumWrites || rd_issued[i] != NumReads || open_cnt[i] != 0) begin
        done = 1'b0;
      end
    end
    return done;
  endfunction

  task automatic report_mismatch(input string sig, input logic [31:0] exp_val,
                                 input logic [31:0] got_val);
    $display("ERR time=%0t %s expected=%h got=%h", $time, sig, exp_val, got_val);
    err_cnt++;
  endtask

  task automatic drive_initiators();
    logic [31:0] rnd;
    addr_t       addr;
    r_chan_t     er;
    logic        busy;
    logic        wr_hs;
    for (int i = 0; i < NumSlvPorts; i++) begin
      if (slv_resp[i].b_valid && slv_req[i].b_ready) begin
        if (exp_b[i].size() == 0) begin
          $display("Write response without a request at initiator %0d, time %0t", i, $time);
          err_cnt++;
        end else begin
          if (slv_resp[i].b.resp != exp_b[i][0]) begin
            report_mismatch($sformatf("slv_resp_o[%0d].b.resp", i),
                            32'(exp_b[i][0]), 32'(slv_resp[i].b.resp));
          end
          void'(exp_b[i].pop_front());
          open_cnt[i]--;
          rsp_cnt++;
        end
      end
      if (slv_resp[i].r_valid && slv_req[i].r_ready) begin
        if (exp_r[i].size() == 0) begin
          $display("Read response without a request at initiator %0d, time %0t", i, $time);
          err_cnt++;
        end else begin
          if (slv_resp[i].r.resp != exp_r[i][0].resp) begin
            report_mismatch($sformatf("slv_resp_o[%0d].r.resp", i),
                            32'(exp_r[i][0].resp), 32'(slv_resp[i].r.resp));
          end
          if (slv_resp[i].r.data != exp_r[i][0].data) begin
            report_mismatch($sformatf("slv_resp_o[%0d].r.data", i),
                            exp_r[i][0].data, slv_resp[i].r.data);
          end
          void'(exp_r[i].pop_front());
          open_cnt[i]--;
          rsp_cnt++;
        end
      end

      // Write request channel
      busy  = slv_req[i].wq_valid;
      wr_hs = slv_req[i].wq_valid && slv_resp[i].wq_ready;
      if (wr_hs) begin
        addr = slv_req[i].wq.addr;
        exp_b[i].push_back(addr[15] ? RespSlvErr : RespOkay);
        mapped_cnt += addr[15] ? 0 : 1;
        busy = 1'b0;
      end
      rnd = take_bits(1);
      if (!busy && wr_issued[i] < NumWrites && rnd[0]) begin
        slv_req[i].wq.addr  <= pick_addr(i);
        slv_req[i].wq.data  <= take_bits(32);
        rnd = take_bits(4);
        slv_req[i].wq.strb  <= rnd[3:0];
        slv_req[i].wq_valid <= 1'b1;
        wr_issued[i]++;
        open_cnt[i]++;
      end else if (!busy) begin
        slv_req[i].wq_valid <= 1'b0;
      end

      // Read request channel
      busy = slv_req[i].ar_valid;
      if (slv_req[i].ar_valid && slv_resp[i].ar_ready) begin
        addr    = slv_req[i].ar.addr;
        er.data = addr[15] ? DecErrData : ref_mem[addr[14]][addr[5:2]];  // Before this cycle's write
        er.resp = addr[15] ? RespSlvErr : RespOkay;
        exp_r[i].push_back(er);
        mapped_cnt += addr[15] ? 0 : 1;
        busy = 1'b0;
      end
      rnd = take_bits(1);
      if (!busy && rd_issued[i] < NumReads && rnd[0]) begin
        slv_req[i].ar.addr  <= pick_addr(i);
        slv_req[i].ar_valid <= 1'b1;
        rd_issued[i]++;
        open_cnt[i]++;
      end else if (!busy) begin
        slv_req[i].ar_valid <= 1'b0;
      end

      // Reference takes the driven write once the read above has sampled it
      if (wr_hs && !slv_req[i].wq.addr[15]) begin
        addr = slv_req[i].wq.addr;
        ref_mem[addr[14]][addr[5:2]] = merge_strobes(ref_mem[addr[14]][addr[5:2]],
                                                     slv_req[i].wq.data, slv_req[i].wq.strb);
      end

      rnd = take_bits(4);
      slv_req[i].b_ready <= rnd[0] | rnd[1];  // Ready about three cycles in four
      slv_req[i].r_ready <= rnd[2] | rnd[3];
    end
  endtask

  task automatic serve_targets();
    logic [31:0] rnd;
    addr_t       addr;
    logic        busy;
    for (int t = 0; t < NumMstPorts; t++) begin
      if (mst_req[t].ar_valid && mst_resp[t].ar_ready) begin
        addr = mst_req[t].ar.addr;
        if (addr[15] || addr[14] != t[0]) begin
          $display("Read of address %h arrived at target %0d, time %0t", addr, t, $time);
          err_cnt++;
        end
        r_pend[t].push_back(tmem[t][addr[5:2]]);
        tgt_hs_cnt++;
      end
      if (mst_req[t].wq_valid && mst_resp[t].wq_ready) begin
        addr = mst_req[t].wq.addr;
        if (addr[15] || addr[14] != t[0]) begin
          $display("Write to address %h arrived at target %0d, time %0t", addr, t, $time);
          err_cnt++;
        end
        tmem[t][addr[5:2]] = merge_strobes(tmem[t][addr[5:2]], mst_req[t].wq.data,
                                           mst_req[t].wq.strb);
        b_pend[t]++;
        tgt_hs_cnt++;
      end

      // Responses go out in order after a random delay
      rnd  = take_bits(6);
      busy = mst_resp[t].b_valid && !mst_req[t].b_ready;
      if (mst_resp[t].b_valid && mst_req[t].b_ready) begin
        b_pend[t]--;
      end
      if (!busy) begin
        mst_resp[t].b.resp  <= RespOkay;
        mst_resp[t].b_valid <= (b_pend[t] > 0) && rnd[0];
      end
      busy = mst_resp[t].r_valid && !mst_req[t].r_ready;
      if (mst_resp[t].r_valid && mst_req[t].r_ready) begin
        void'(r_pend[t].pop_front());
      end
      if (!busy && r_pend[t].size() > 0 && rnd[1]) begin
        mst_resp[t].r.data  <= r_pend[t][0];
        mst_resp[t].r.resp  <= RespOkay;
        mst_resp[t].r_valid <= 1'b1;
      end else if (!busy) begin
        mst_resp[t].r_valid <= 1'b0;
      end
      mst_resp[t].wq_ready <= rnd[2] | rnd[3];
      mst_resp[t].ar_ready <= rnd[4] | rnd[5];
    end
  endtask

  initial begin
    rst_n    <= 1'b0;
    slv_req  <= '0;
    mst_resp <= '0;
    addr_map[0] <= '{idx: mst_idx_t'(0), start_addr: 16'h0000, end_addr: 16'h4000};
    addr_map[1] <= '{idx: mst_idx_t'(1), start_addr: 16'h4000, end_addr: 16'h8000};
    mapped_cnt = 0;
    tgt_hs_cnt = 0;
    rsp_cnt    = 0;
    err_cnt    = 0;
    cycle_cnt  = 0;
    for (int i = 0; i < NumSlvPorts; i++) begin
      wr_issued[i] = 0;
      rd_issued[i] = 0;
      open_cnt[i]  = 0;
    end
    for (int t = 0; t < NumMstPorts; t++) begin
      b_pend[t] = 0;
      for (int w = 0; w < 16; w++) begin
        tmem[t][w]    = {16'hC0DE, 16'(t * 16'h4000 + w * 4)};  // Word holds its own address
        ref_mem[t][w] = {16'hC0DE, 16'(t * 16'h4000 + w * 4)};
      end
    end

    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    for (int i = 0; i < NumSlvPorts; i++) begin
      if (slv_resp[i].b_valid || slv_resp[i].r_valid) begin
        $display("Response valid high on initiator port %0d after reset", i);
        err_cnt++;
      end
    end
    for (int t = 0; t < NumMstPorts; t++) begin
      if (mst_req[t].wq_valid || mst_req[t].ar_valid) begin
        $display("Request valid high on target port %0d after reset", t);
        err_cnt++;
      end
    end

    while (!traffic_done() && cycle_cnt < MaxCycles) begin
      @(posedge clk);
      cycle_cnt++;
      drive_initiators();
      serve_targets();
    end

    if (!traffic_done()) begin
      $display("Run stopped at the limit of %0d cycles with transactions outstanding",
               MaxCycles);
      err_cnt++;
    end
    if (tgt_hs_cnt != mapped_cnt) begin
      report_mismatch("target port handshakes", 32'(mapped_cnt), 32'(tgt_hs_cnt));
    end
    $display("Errors %0d, responses checked %0d, mapped requests %0d, target handshakes %0d",
             err_cnt, rsp_cnt, mapped_cnt, tgt_hs_cnt);
    if (err_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- hdl/lite_xbar.sv
// Crossbar top level connecting every initiator to every target through demuxes and muxes
`default_nettype none

module lite_xbar (
  input  logic                                                       clk_i,
  input  logic                                                       rst_n_i,
  input  lite_xbar_pkg::lite_req_t  [lite_xbar_pkg::NumSlvPorts-1:0] slv_req_i,
  output lite_xbar_pkg::lite_resp_t [lite_xbar_pkg::NumSlvPorts-1:0] slv_resp_o,
  output lite_xbar_pkg::lite_req_t  [lite_xbar_pkg::NumMstPorts-1:0] mst_req_o,
  input  lite_xbar_pkg::lite_resp_t [lite_xbar_pkg::NumMstPorts-1:0] mst_resp_i,
  input  lite_xbar_pkg::addr_rule_t [lite_xbar_pkg::NumRules-1:0]    addr_map_i
);
  import lite_xbar_pkg::*;

  // Demux outputs, the last index of each initiator goes to its error responder
  lite_req_t  [NumSlvPorts-1:0][NumMstPorts:0]   demux_reqs;
  lite_resp_t [NumSlvPorts-1:0][NumMstPorts:0]   demux_resps;
  lite_req_t  [NumMstPorts-1:0][NumSlvPorts-1:0] mux_reqs;
  lite_resp_t [NumMstPorts-1:0][NumSlvPorts-1:0] mux_resps;

  for (genvar i = 0; i < NumSlvPorts; i++) begin : gen_slv
    sel_t wq_sel;
    sel_t ar_sel;

    lite_addr_decode wq_decode_inst (
      .addr_i     (slv_req_i[i].wq.addr),
      .addr_map_i (addr_map_i),
      .idx_o      (wq_sel)
    );

    lite_addr_decode ar_decode_inst (
      .addr_i     (slv_req_i[i].ar.addr),
      .addr_map_i (addr_map_i),
      .idx_o      (ar_sel)
    );

    lite_demux demux_inst (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .slv_req_i   (slv_req_i[i]),
      .slv_resp_o  (slv_resp_o[i]),
      .wq_sel_i    (wq_sel),
      .ar_sel_i    (ar_sel),
      .mst_reqs_o  (demux_reqs[i]),
      .mst_resps_i (demux_resps[i])
    );

    lite_decerr_slv decerr_inst (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .slv_req_i  (demux_reqs[i][NumMstPorts]),
      .slv_resp_o (demux_resps[i][NumMstPorts])
    );
  end

  // Demux output j of initiator i meets mux input i of target j
  for (genvar i = 0; i < NumSlvPorts; i++) begin : gen_cross_slv
    for (genvar j = 0; j < NumMstPorts; j++) begin : gen_cross_mst
      assign mux_reqs[j][i]    = demux_reqs[i][j];
      assign demux_resps[i][j] = mux_resps[j][i];
    end
  end

  for (genvar j = 0; j < NumMstPorts; j++) begin : gen_mst
    lite_mux mux_inst (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .slv_reqs_i  (mux_reqs[j]),
      .slv_resps_o (mux_resps[j]),
      .mst_req_o   (mst_req_o[j]),
      .mst_resp_i  (mst_resp_i[j])
    );
  end

endmodule

`default_nettype wire

//--- hdl/lite_decerr_slv.sv
// Error responder behind each initiator's demux, answering requests that hit no address rule
`default_nettype none

module lite_decerr_slv (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  lite_xbar_pkg::lite_req_t  slv_req_i,
  output lite_xbar_pkg::lite_resp_t slv_resp_o
);
  import lite_xbar_pkg::*;

  logic b_pending_q;
  logic r_pending_q;

  // One transaction per channel at a time
  always_comb begin
    slv_resp_o          = '0;
    slv_resp_o.wq_ready = !b_pending_q;
    slv_resp_o.b_valid  = b_pending_q;
    slv_resp_o.b.resp   = RespSlvErr;
    slv_resp_o.ar_ready = !r_pending_q;
    slv_resp_o.r_valid  = r_pending_q;
    slv_resp_o.r.data   = DecErrData;  // Recognizable pattern for bad reads
    slv_resp_o.r.resp   = RespSlvErr;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      b_pending_q <= 1'b0;
      r_pending_q <= 1'b0;
    end else begin
      if (b_pending_q) begin
        b_pending_q <= !slv_req_i.b_ready;  // Clears on B handshake
      end else begin
        b_pending_q <= slv_req_i.wq_valid;
      end
      if (r_pending_q) begin
        r_pending_q <= !slv_req_i.r_ready;
      end else begin
        r_pending_q <= slv_req_i.ar_valid;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/lite_mux.sv
// Round-robin arbiter in front of one target, returning responses in grant order
`default_nettype none

module lite_mux (
  input  logic                                                       clk_i,
  input  logic                                                       rst_n_i,
  input  lite_xbar_pkg::lite_req_t  [lite_xbar_pkg::NumSlvPorts-1:0] slv_reqs_i,
  output lite_xbar_pkg::lite_resp_t [lite_xbar_pkg::NumSlvPorts-1:0] slv_resps_o,
  output lite_xbar_pkg::lite_req_t                                   mst_req_o,
  input  lite_xbar_pkg::lite_resp_t                                  mst_resp_i
);
  import lite_xbar_pkg::*;

  logic     [NumDirs-1:0][NumSlvPorts-1:0] req_valid;
  logic     [NumDirs-1:0][NumSlvPorts-1:0] req_ready;
  logic     [NumDirs-1:0][NumSlvPorts-1:0] rsp_valid;
  logic     [NumDirs-1:0][NumSlvPorts-1:0] rsp_ready;
  logic     [NumDirs-1:0]                  out_valid;
  logic     [NumDirs-1:0]                  out_ready;
  logic     [NumDirs-1:0]                  out_rsp_valid;
  logic     [NumDirs-1:0]                  out_rsp_ready;
  slv_idx_t [NumDirs-1:0]                  grant;

  for (genvar i = 0; i < NumSlvPorts; i++) begin : gen_unpack
    assign req_valid[DirWr][i] = slv_reqs_i[i].wq_valid;
    assign req_valid[DirRd][i] = slv_reqs_i[i].ar_valid;
    assign rsp_ready[DirWr][i] = slv_reqs_i[i].b_ready;
    assign rsp_ready[DirRd][i] = slv_reqs_i[i].r_ready;
  end

  assign out_ready[DirWr]     = mst_resp_i.wq_ready;
  assign out_ready[DirRd]     = mst_resp_i.ar_ready;
  assign out_rsp_valid[DirWr] = mst_resp_i.b_valid;
  assign out_rsp_valid[DirRd] = mst_resp_i.r_valid;

  for (genvar d = 0; d < NumDirs; d++) begin : gen_dir
    slv_idx_t rr_idx;
    slv_idx_t prio_q;      // Last granted initiator
    slv_idx_t lock_idx_q;
    logic     locked_q;
    logic     out_hs;
    logic     rsp_hs;
    logic     full;
    logic     empty;
    slv_idx_t head;
    slv_idx_t fifo_q [MaxTrans];
    ptr_t     wr_ptr_q;
    ptr_t     rd_ptr_q;
    cnt_t     cnt_q;

    // Search starts just after the last winner
    always_comb begin
      slv_idx_t cand;
      logic     found;
      rr_idx = prio_q;
      found  = 1'b0;
      for (int n = 1; n <= NumSlvPorts; n++) begin
        cand = slv_idx_t'((int'(prio_q) + n) % NumSlvPorts);
        if (!found && req_valid[d][cand]) begin
          rr_idx = cand;
          found  = 1'b1;
        end
      end
    end

    assign grant[d]         = locked_q ? lock_idx_q : rr_idx;
    assign full             = (cnt_q == cnt_t'(MaxTrans));
    assign empty            = (cnt_q == '0);
    assign head             = fifo_q[rd_ptr_q];
    assign out_valid[d]     = req_valid[d][grant[d]] && !full;
    assign out_hs           = out_valid[d] && out_ready[d];
    assign out_rsp_ready[d] = !empty && rsp_ready[d][head];  // Only the FIFO head may take it
    assign rsp_hs           = out_rsp_valid[d] && out_rsp_ready[d];

    for (genvar i = 0; i < NumSlvPorts; i++) begin : gen_route
      assign req_ready[d][i] = (grant[d] == slv_idx_t'(i)) && !full && out_ready[d];
      assign rsp_valid[d][i] = (head == slv_idx_t'(i)) && !empty && out_rsp_valid[d];
    end

    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        prio_q     <= '0;
        lock_idx_q <= '0;
        locked_q   <= 1'b0;
        wr_ptr_q   <= '0;
        rd_ptr_q   <= '0;
        cnt_q      <= '0;
      end else begin
        locked_q   <= req_valid[d][grant[d]] && !out_hs;  // Hold until handshake
        lock_idx_q <= grant[d];
        if (out_hs) begin
          prio_q   <= grant[d];
          wr_ptr_q <= wr_ptr_q + ptr_t'(1);
        end
        if (rsp_hs) begin
          rd_ptr_q <= rd_ptr_q + ptr_t'(1);
        end
        cnt_q <= cnt_q + cnt_t'(out_hs) - cnt_t'(rsp_hs);
      end
    end

    always_ff @(posedge clk_i) begin
      if (out_hs) begin
        fifo_q[wr_ptr_q] <= grant[d];
      end
    end
  end

  always_comb begin
    mst_req_o          = '0;
    mst_req_o.wq       = slv_reqs_i[grant[DirWr]].wq;
    mst_req_o.wq_valid = out_valid[DirWr];
    mst_req_o.ar       = slv_reqs_i[grant[DirRd]].ar;
    mst_req_o.ar_valid = out_valid[DirRd];
    mst_req_o.b_ready  = out_rsp_ready[DirWr];
    mst_req_o.r_ready  = out_rsp_ready[DirRd];
    for (int i = 0; i < NumSlvPorts; i++) begin
      slv_resps_o[i]          = '0;
      slv_resps_o[i].b        = mst_resp_i.b;
      slv_resps_o[i].r        = mst_resp_i.r;
      slv_resps_o[i].b_valid  = rsp_valid[DirWr][i];
      slv_resps_o[i].r_valid  = rsp_valid[DirRd][i];
      slv_resps_o[i].wq_ready = req_ready[DirWr][i];
      slv_resps_o[i].ar_ready = req_ready[DirRd][i];
    end
  end

endmodule

`default_nettype wire

//--- hdl/lite_demux.sv
// Request steering for one initiator, feeding both targets and the local error responder
`default_nettype none

module lite_demux (
  input  logic                                                     clk_i,
  input  logic                                                     rst_n_i,
  input  lite_xbar_pkg::lite_req_t                                 slv_req_i,
  output lite_xbar_pkg::lite_resp_t                                slv_resp_o,
  input  lite_xbar_pkg::sel_t                                      wq_sel_i,
  input  lite_xbar_pkg::sel_t                                      ar_sel_i,
  output lite_xbar_pkg::lite_req_t  [lite_xbar_pkg::NumMstPorts:0] mst_reqs_o,
  input  lite_xbar_pkg::lite_resp_t [lite_xbar_pkg::NumMstPorts:0] mst_resps_i
);
  import lite_xbar_pkg::*;

  sel_t [NumDirs-1:0]                sel_in;
  logic [NumDirs-1:0]                in_valid;
  logic [NumDirs-1:0]                in_ready;
  logic [NumDirs-1:0]                up_rsp_valid;
  logic [NumDirs-1:0]                up_rsp_ready;
  logic [NumDirs-1:0][NumMstPorts:0] down_ready;
  logic [NumDirs-1:0][NumMstPorts:0] down_rsp_valid;
  logic [NumDirs-1:0]                busy;
  logic [NumDirs-1:0]                free;
  sel_t [NumDirs-1:0]                rsp_sel;  // Where in-flight responses come from

  assign sel_in[DirWr]       = wq_sel_i;
  assign sel_in[DirRd]       = ar_sel_i;
  assign in_valid[DirWr]     = slv_req_i.wq_valid;
  assign in_valid[DirRd]     = slv_req_i.ar_valid;
  assign up_rsp_ready[DirWr] = slv_req_i.b_ready;
  assign up_rsp_ready[DirRd] = slv_req_i.r_ready;

  for (genvar k = 0; k <= NumMstPorts; k++) begin : gen_unpack
    assign down_ready[DirWr][k]     = mst_resps_i[k].wq_ready;
    assign down_ready[DirRd][k]     = mst_resps_i[k].ar_ready;
    assign down_rsp_valid[DirWr][k] = mst_resps_i[k].b_valid;
    assign down_rsp_valid[DirRd][k] = mst_resps_i[k].r_valid;
  end

  for (genvar d = 0; d < NumDirs; d++) begin : gen_dir
    cnt_t cnt_q;
    sel_t sel_q;
    logic ready_sel;
    logic rsp_valid_sel;
    logic in_hs;
    logic rsp_hs;

    assign busy[d]    = (cnt_q != '0);
    // Same path as the in-flight ones keeps responses in order
    assign free[d]    = !busy[d] ||
                        ((sel_in[d] == sel_q) && (cnt_q != cnt_t'(MaxTrans)));
    assign rsp_sel[d] = sel_q;

    always_comb begin
      ready_sel     = 1'b0;
      rsp_valid_sel = 1'b0;
      for (int k = 0; k <= NumMstPorts; k++) begin
        if (sel_in[d] == sel_t'(k)) begin
          ready_sel = free[d] && down_ready[d][k];  // Target stall passes straight up
        end
        if (sel_q == sel_t'(k)) begin
          rsp_valid_sel = busy[d] && down_rsp_valid[d][k];
        end
      end
    end

    assign in_ready[d]     = ready_sel;
    assign up_rsp_valid[d] = rsp_valid_sel;
    assign in_hs           = in_valid[d] && in_ready[d];
    assign rsp_hs          = up_rsp_valid[d] && up_rsp_ready[d];

    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        cnt_q <= '0;
        sel_q <= '0;
      end else begin
        if (in_hs) begin
          sel_q <= sel_in[d];
        end
        cnt_q <= cnt_q + cnt_t'(in_hs) - cnt_t'(rsp_hs);
      end
    end
  end

  always_comb begin
    slv_resp_o          = '0;
    slv_resp_o.wq_ready = in_ready[DirWr];
    slv_resp_o.ar_ready = in_ready[DirRd];
    slv_resp_o.b_valid  = up_rsp_valid[DirWr];
    slv_resp_o.r_valid  = up_rsp_valid[DirRd];
    for (int k = 0; k <= NumMstPorts; k++) begin
      mst_reqs_o[k]    = '0;
      mst_reqs_o[k].wq = slv_req_i.wq;  // Payload to all, valid to one
      mst_reqs_o[k].ar = slv_req_i.ar;
      mst_reqs_o[k].wq_valid = in_valid[DirWr] && free[DirWr] &&
                               (sel_in[DirWr] == sel_t'(k));
      mst_reqs_o[k].ar_valid = in_valid[DirRd] && free[DirRd] &&
                               (sel_in[DirRd] == sel_t'(k));
      mst_reqs_o[k].b_ready  = up_rsp_ready[DirWr] && busy[DirWr] &&
                               (rsp_sel[DirWr] == sel_t'(k));
      mst_reqs_o[k].r_ready  = up_rsp_ready[DirRd] && busy[DirRd] &&
                               (rsp_sel[DirRd] == sel_t'(k));
      if (rsp_sel[DirWr] == sel_t'(k)) begin
        slv_resp_o.b = mst_resps_i[k].b;
      end
      if (rsp_sel[DirRd] == sel_t'(k)) begin
        slv_resp_o.r = mst_resps_i[k].r;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/lite_addr_decode.sv
// Address to target decoder, one per request channel of each crossbar slave port
`default_nettype none

module lite_addr_decode (
  input  lite_xbar_pkg::addr_t                                    addr_i,
  input  lite_xbar_pkg::addr_rule_t [lite_xbar_pkg::NumRules-1:0] addr_map_i,
  output lite_xbar_pkg::sel_t                                     idx_o
);
  import lite_xbar_pkg::*;

  logic [NumRules-1:0] hit;  // One bit per rule window

  for (genvar r = 0; r < NumRules; r++) begin : gen_rule
    assign hit[r] = (addr_i >= addr_map_i[r].start_addr) &&
                    (addr_i <  addr_map_i[r].end_addr);
  end

  // Scan upward so that the last matching rule wins
  always_comb begin
    idx_o = sel_t'(NumMstPorts);  // No match goes to the error responder
    for (int r = 0; r < NumRules; r++) begin
      if (hit[r]) begin
        idx_o = sel_t'(addr_map_i[r].idx);
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/lite_xbar_pkg.sv
// Shared sizes, channel structs and rule type of the AXI4-Lite crossbar, imported by each module
`default_nettype none

package lite_xbar_pkg;

  localparam int unsigned NumSlvPorts = 2;  // Initiators
  localparam int unsigned NumMstPorts = 2;  // Targets
  localparam int unsigned NumRules    = 2;
  localparam int unsigned AddrWidth   = 16;
  localparam int unsigned DataWidth   = 32;
  localparam int unsigned StrbWidth   = DataWidth / 8;

  // Outstanding transactions per direction, kept a power of two so FIFO pointers wrap
  localparam int unsigned MaxTrans = 4;
  localparam int unsigned CntWidth = $clog2(MaxTrans + 1);
  localparam int unsigned PtrWidth = $clog2(MaxTrans);

  // Write side (WQ/B) and read side (AR/R) share the per-direction logic
  localparam int unsigned NumDirs = 2;
  localparam int unsigned DirWr   = 0;
  localparam int unsigned DirRd   = 1;

  typedef logic [AddrWidth-1:0]               addr_t;
  typedef logic [DataWidth-1:0]               data_t;
  typedef logic [StrbWidth-1:0]               strb_t;
  typedef logic [1:0]                         resp_code_t;
  typedef logic [$clog2(NumMstPorts)-1:0]     mst_idx_t;
  typedef logic [$clog2(NumMstPorts + 1)-1:0] sel_t;  // NumMstPorts picks the error responder
  typedef logic [$clog2(NumSlvPorts)-1:0]     slv_idx_t;
  typedef logic [CntWidth-1:0]                cnt_t;
  typedef logic [PtrWidth-1:0]                ptr_t;

  localparam data_t      DecErrData = 32'hBADCAB1E;
  localparam resp_code_t RespOkay   = 2'b00;
  localparam resp_code_t RespSlvErr = 2'b10;

  // Write address and data travel together as one request
  typedef struct packed {
    addr_t addr;
    data_t data;
    strb_t strb;
  } wq_chan_t;

  typedef struct packed {
    resp_code_t resp;
  } b_chan_t;

  typedef struct packed {
    addr_t addr;
  } ar_chan_t;

  typedef struct packed {
    data_t      data;
    resp_code_t resp;
  } r_chan_t;

  typedef struct packed {
    wq_chan_t wq;
    logic     wq_valid;
    ar_chan_t ar;
    logic     ar_valid;
    logic     b_ready;
    logic     r_ready;
  } lite_req_t;

  typedef struct packed {
    b_chan_t b;
    logic    b_valid;
    r_chan_t r;
    logic    r_valid;
    logic    wq_ready;
    logic    ar_ready;
  } lite_resp_t;

  // Covers start_addr up to but excluding end_addr
  typedef struct packed {
    mst_idx_t idx;
    addr_t    start_addr;
    addr_t    end_addr;
  } addr_rule_t;

endpackage

`default_nettype wire
